// File: design/eqPath_config.svh
`ifndef EQPATH_CONFIG_SVH
`define EQPATH_CONFIG_SVH

`define SAMPLE_WIDTH      16          // bits per audio sample
`define DAC_WORD_WIDTH    24          // cmd nibble, channel nibble, sample
`define SCK_HALF          2           // system clocks per sck half period
`define SAMPLE_PERIOD     300         // clocks between adc frame starts

`define GAIN_UNITY        16'h4000    // 1.0 in q2.14
`define GAIN_FRAC         14

`define HOST_ADDR_WIDTH   9
`define HOST_DATA_WIDTH   32
`define GAIN_OFFSET       4'hC        // low address nibble of a gain register

`define ADC_CMD_CH0       16'h8000
`define ADC_CMD_CH1       16'hC000
`define DAC_TRANSMIT      4'd3        // write and update

`endif

// File: design/eqPathPkg.sv
`include "eqPath_config.svh"

package eqPathPkg;

    typedef logic [`SAMPLE_WIDTH-1:0]        sample_t;     // offset binary or two's complement
    typedef logic signed [`SAMPLE_WIDTH-1:0] gain_t;       // q2.14, same width as a sample
    typedef logic                            channel_t;
    typedef logic [`DAC_WORD_WIDTH-1:0]      dacWord_t;
    typedef logic [`HOST_ADDR_WIDTH-1:0]     hostAddr_t;
    typedef logic [`HOST_DATA_WIDTH-1:0]     hostData_t;

    // one sample moving down the pipeline with its channel tag
    typedef struct packed {
        channel_t channel;
        sample_t  sample;
    } sampleBeat_t;

    typedef struct packed {
        gain_t ch1;
        gain_t ch0;
    } gainPair_t;

    // shared by both spi masters
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        DONE
    } spiState_t;

endpackage

// File: design/gainRegs.sv
`include "eqPath_config.svh"

module gainRegs import eqPathPkg::*; (
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,
    input  logic      hostWr,
    input  hostAddr_t hostAddr,
    input  hostData_t hostData,
    input  logic      frameDone,
    output gainPair_t activeGains
);

    gainPair_t stagedGains;
    logic      gainHit;                 // host write lands on a gain register

    assign gainHit = hostWr && (hostAddr[3:0] == `GAIN_OFFSET);

    // staging copy, host may write it at any time
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            stagedGains.ch0 <= `GAIN_UNITY;
            stagedGains.ch1 <= `GAIN_UNITY;
        end else if (gainHit) begin
            if (hostAddr[4]) begin      // bit 4 picks the channel
                stagedGains.ch1 <= hostData[`SAMPLE_WIDTH-1:0];
            end else begin
                stagedGains.ch0 <= hostData[`SAMPLE_WIDTH-1:0];
            end
        end
    end

    // Both channels switch at the same frame boundary, so a left/right
    // pair is never processed with a half updated gain set.
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            activeGains.ch0 <= `GAIN_UNITY;
            activeGains.ch1 <= `GAIN_UNITY;
        end else if (frameDone) begin
            activeGains <= stagedGains;
        end
    end

endmodule

// File: design/adcReader.sv
`include "eqPath_config.svh"

module adcReader import eqPathPkg::*; (
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        ADC_SDO,
    output logic        ADC_SCK,
    output logic        ADC_SDI,
    output logic        ADC_CONV_CS,
    output logic        sampleValid,
    output sampleBeat_t rawBeat
);

    localparam int PERIOD_W = $clog2(`SAMPLE_PERIOD);
    localparam int DIV_W    = $clog2(`SCK_HALF + 1);
    localparam int BIT_W    = $clog2(`SAMPLE_WIDTH);
    localparam int MSB      = `SAMPLE_WIDTH - 1;

    localparam logic [PERIOD_W-1:0] PERIOD_LAST = PERIOD_W'(`SAMPLE_PERIOD - 1);
    localparam logic [DIV_W-1:0]    DIV_LAST    = DIV_W'(`SCK_HALF - 1);
    localparam logic [BIT_W-1:0]    BIT_LAST    = BIT_W'(`SAMPLE_WIDTH - 1);

    spiState_t             state;
    logic [PERIOD_W-1:0]   periodCnt;
    logic [DIV_W-1:0]      divCnt;
    logic [BIT_W-1:0]      bitCnt;
    sample_t               nextCmd;
    sample_t               cmdShift;
    sample_t               dataShift;
    channel_t              lastCh;      // channel commanded by the previous frame
    channel_t              dataCh;      // tag for the word coming in now
    logic                  frameStart;
    logic                  sckEdge;
    logic                  lastRiseSeen;

    ////////////////////////////////////////////////////////////////////////////
    // sample timer

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            periodCnt <= '0;
        end else if (periodCnt == PERIOD_LAST) begin
            periodCnt <= '0;
        end else begin
            periodCnt <= periodCnt + 1'b1;
        end
    end

    assign frameStart   = (periodCnt == '0) && (state == IDLE);
    assign sckEdge      = (state == SHIFT) && (divCnt == DIV_LAST);
    assign nextCmd      = lastCh ? `ADC_CMD_CH0 : `ADC_CMD_CH1;  // alternate channels
    // first clock of the high half after the final rising edge
    assign lastRiseSeen = (state == SHIFT) && ADC_SCK && (bitCnt == BIT_LAST) && (divCnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // spi framing

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state       <= IDLE;
            ADC_CONV_CS <= 1'b1;
            ADC_SCK     <= 1'b0;
            ADC_SDI     <= 1'b0;
            divCnt      <= '0;
            bitCnt      <= '0;
            lastCh      <= 1'b1;        // so the first frame asks for channel 0
            dataCh      <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (frameStart) begin
                        state       <= SHIFT;
                        ADC_CONV_CS <= 1'b0;
                        ADC_SDI     <= nextCmd[MSB];
                        divCnt      <= '0;
                        bitCnt      <= '0;
                        lastCh      <= ~lastCh;
                        dataCh      <= lastCh;  // adc answers one frame late
                    end
                end
                SHIFT: begin
                    if (divCnt == DIV_LAST) begin
                        divCnt  <= '0;
                        ADC_SCK <= ~ADC_SCK;
                        if (ADC_SCK) begin      // falling edge
                            if (bitCnt == BIT_LAST) begin
                                state       <= DONE;
                                ADC_CONV_CS <= 1'b1;
                                ADC_SDI     <= 1'b0;
                            end else begin
                                bitCnt  <= bitCnt + 1'b1;
                                ADC_SDI <= cmdShift[MSB];
                            end
                        end
                    end else begin
                        divCnt <= divCnt + 1'b1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // command goes out on falling edges, sdo comes in on rising edges
    always_ff @(posedge S_AXI_ACLK) begin
        if (frameStart) begin
            cmdShift <= {nextCmd[MSB-1:0], 1'b0};
        end else if (sckEdge && ADC_SCK) begin
            cmdShift <= {cmdShift[MSB-1:0], 1'b0};
        end
        if (sckEdge && !ADC_SCK) begin
            dataShift <= {dataShift[MSB-1:0], ADC_SDO};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sample output

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= lastRiseSeen;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (lastRiseSeen) begin
            rawBeat.channel <= dataCh;
            rawBeat.sample  <= dataShift;   // still offset binary
        end
    end

endmodule

// File: design/gainStage.sv
`include "eqPath_config.svh"

module gainStage import eqPathPkg::*; (
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        sampleValid,
    input  sampleBeat_t rawBeat,
    input  gainPair_t   activeGains,
    output logic        scaledValid,
    output sampleBeat_t scaledBeat
);

    localparam int MSB    = `SAMPLE_WIDTH - 1;
    localparam int PROD_W = 2 * `SAMPLE_WIDTH;

    localparam logic signed [PROD_W-1:0] SAT_MAX = PROD_W'((2 ** MSB) - 1);
    localparam logic signed [PROD_W-1:0] SAT_MIN = PROD_W'(-(2 ** MSB));

    logic signed [MSB:0]      signedSample;
    gain_t                    chGain;
    logic signed [PROD_W-1:0] product;
    logic signed [PROD_W-1:0] shifted;
    logic                     prodValid;
    channel_t                 prodCh;
    sample_t                  saturated;

    assign signedSample = {~rawBeat.sample[MSB], rawBeat.sample[MSB-1:0]};  // offset -> 2's comp
    assign chGain       = rawBeat.channel ? activeGains.ch1 : activeGains.ch0;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, multiply

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            prodValid <= 1'b0;
        end else begin
            prodValid <= sampleValid;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (sampleValid) begin
            product <= signedSample * chGain;   // full 32 bit signed product
            prodCh  <= rawBeat.channel;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2, rescale and clamp

    assign shifted = product >>> `GAIN_FRAC;

    always_comb begin
        if (shifted > SAT_MAX) begin
            saturated = SAT_MAX[MSB:0];
        end else if (shifted < SAT_MIN) begin
            saturated = SAT_MIN[MSB:0];
        end else begin
            saturated = shifted[MSB:0];
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            scaledValid <= 1'b0;
        end else begin
            scaledValid <= prodValid;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (prodValid) begin
            scaledBeat.channel <= prodCh;
            scaledBeat.sample  <= saturated;
        end
    end

endmodule

// File: design/dacWriter.sv
`include "eqPath_config.svh"

module dacWriter import eqPathPkg::*; (
    input  logic        S_AXI_ACLK,
    input  logic        S_AXI_ARESETN,
    input  logic        scaledValid,
    input  sampleBeat_t scaledBeat,
    output logic        DAC_SCK,
    output logic        DAC_SDI,
    output logic        DAC_CONV_CS,
    output logic        frameDone
);

    localparam int DIV_W    = $clog2(`SCK_HALF + 1);
    localparam int BIT_W    = $clog2(`DAC_WORD_WIDTH);
    localparam int MSB      = `SAMPLE_WIDTH - 1;
    localparam int WORD_MSB = `DAC_WORD_WIDTH - 1;

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCK_HALF - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`DAC_WORD_WIDTH - 1);

    spiState_t        state;
    logic [DIV_W-1:0] divCnt;
    logic [BIT_W-1:0] bitCnt;
    dacWord_t         word;
    dacWord_t         wordShift;
    logic             frameStart;
    logic             sckEdge;

    // transmit nibble, channel nibble, sample back in offset binary
    assign word = {`DAC_TRANSMIT, 3'b000, scaledBeat.channel,
                   ~scaledBeat.sample[MSB], scaledBeat.sample[MSB-1:0]};

    assign frameStart = scaledValid && (state == IDLE);    // busy frames drop the beat
    assign sckEdge    = (state == SHIFT) && (divCnt == DIV_LAST);

    ////////////////////////////////////////////////////////////////////////////
    // spi framing

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state       <= IDLE;
            DAC_CONV_CS <= 1'b1;
            DAC_SCK     <= 1'b0;
            DAC_SDI     <= 1'b0;
            divCnt      <= '0;
            bitCnt      <= '0;
            frameDone   <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            case (state)
                IDLE: begin
                    if (frameStart) begin
                        state       <= SHIFT;
                        DAC_CONV_CS <= 1'b0;
                        DAC_SDI     <= word[WORD_MSB];
                        divCnt      <= '0;
                        bitCnt      <= '0;
                    end
                end
                SHIFT: begin
                    if (divCnt == DIV_LAST) begin
                        divCnt  <= '0;
                        DAC_SCK <= ~DAC_SCK;
                        if (DAC_SCK) begin      // falling edge
                            if (bitCnt == BIT_LAST) begin
                                state       <= DONE;
                                DAC_CONV_CS <= 1'b1;
                                DAC_SDI     <= 1'b0;
                            end else begin
                                bitCnt  <= bitCnt + 1'b1;
                                DAC_SDI <= wordShift[WORD_MSB];
                            end
                        end
                    end else begin
                        divCnt <= divCnt + 1'b1;
                    end
                end
                DONE: begin
                    frameDone <= 1'b1;  // one clock after cs goes high
                    state     <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (frameStart) begin
            wordShift <= {word[WORD_MSB-1:0], 1'b0};
        end else if (sckEdge && DAC_SCK) begin
            wordShift <= {wordShift[WORD_MSB-1:0], 1'b0};
        end
    end

endmodule

// File: design/eqPath.sv
module eqPath import eqPathPkg::*; (
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,
    input  logic      hostWr,
    input  hostAddr_t hostAddr,
    input  hostData_t hostData,
    input  logic      ADC_SDO,
    output logic      ADC_SCK,
    output logic      ADC_SDI,
    output logic      ADC_CONV_CS,
    output logic      DAC_SCK,
    output logic      DAC_SDI,
    output logic      DAC_CONV_CS
);

    logic        sampleValid;
    sampleBeat_t rawBeat;           // offset binary from the adc
    logic        scaledValid;
    sampleBeat_t scaledBeat;        // two's complement after gain
    logic        frameDone;
    gainPair_t   activeGains;

    gainRegs i_gainRegs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .hostWr        (hostWr),
        .hostAddr      (hostAddr),
        .hostData      (hostData),
        .frameDone     (frameDone),
        .activeGains   (activeGains)
    );

    adcReader i_adcReader (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ADC_SDO       (ADC_SDO),
        .ADC_SCK       (ADC_SCK),
        .ADC_SDI       (ADC_SDI),
        .ADC_CONV_CS   (ADC_CONV_CS),
        .sampleValid   (sampleValid),
        .rawBeat       (rawBeat)
    );

    gainStage i_gainStage (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .sampleValid   (sampleValid),
        .rawBeat       (rawBeat),
        .activeGains   (activeGains),
        .scaledValid   (scaledValid),
        .scaledBeat    (scaledBeat)
    );

    dacWriter i_dacWriter (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .scaledValid   (scaledValid),
        .scaledBeat    (scaledBeat),
        .DAC_SCK       (DAC_SCK),
        .DAC_SDI       (DAC_SDI),
        .DAC_CONV_CS   (DAC_CONV_CS),
        .frameDone     (frameDone)
    );

endmodule

// File: tests/eqPathTb.sv
`include "eqPath_config.svh"

module eqPathTb import eqPathPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;
    localparam int FRAME_BUDGET = 50;   // about 40 frames of tests plus margin
    localparam int MAX_CYCLES   = RESET_CYCLES + FRAME_BUDGET * `SAMPLE_PERIOD;

    logic        S_AXI_ACLK;
    logic        S_AXI_ARESETN;
    logic        hostWr;
    hostAddr_t   hostAddr;
    hostData_t   hostData;
    logic        ADC_SDO;
    logic        ADC_SCK;
    logic        ADC_SDI;
    logic        ADC_CONV_CS;
    logic        DAC_SCK;
    logic        DAC_SDI;
    logic        DAC_CONV_CS;

    int          seed;
    int          errorCount;
    int          failedTests;
    int          testCount;
    int          testStartErrors;
    int          cycleCount;
    int          dacFrames;
    int          clampHits;
    int          adcBits;
    int          dacBits;
    sample_t     adcValue [2];          // what the adc model returns per channel
    gain_t       stagedGain [2];
    gain_t       activeGain [2];
    sampleBeat_t pending [$];           // samples sent by the adc, not yet seen at the dac
    logic        prevAdcCs;
    logic        prevAdcSck;
    logic        prevDacCs;
    logic        prevDacSck;
    sample_t     adcShift;
    sample_t     adcCmd;
    sample_t     expectedCmd;
    channel_t    adcPrevCh;
    channel_t    nextDacCh;
    dacWord_t    dacWord;

    eqPath i_eqPath (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .hostWr        (hostWr),
        .hostAddr      (hostAddr),
        .hostData      (hostData),
        .ADC_SDO       (ADC_SDO),
        .ADC_SCK       (ADC_SCK),
        .ADC_SDI       (ADC_SDI),
        .ADC_CONV_CS   (ADC_CONV_CS),
        .DAC_SCK       (DAC_SCK),
        .DAC_SDI       (DAC_SDI),
        .DAC_CONV_CS   (DAC_CONV_CS)
    );

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES) begin
            @(posedge S_AXI_ACLK);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the tests did not complete", cycleCount);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // idle bus whenever a chip select is high
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
                     ADC_CONV_CS |-> (!ADC_SCK && !ADC_SDI))
        else begin
            errorCount++;
            $display("ADC SCK or SDI moved while ADC_CONV_CS was high");
        end

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
                     DAC_CONV_CS |-> (!DAC_SCK && !DAC_SDI))
        else begin
            errorCount++;
            $display("DAC SCK or SDI moved while DAC_CONV_CS was high");
        end

    ////////////////////////////////////////////////////////////////////////////
    // reference arithmetic and reporting

    function automatic sample_t scaleSample(input sample_t adcCode, input gain_t gain);
        int signedIn;
        int gainVal;
        int scaled;
        signedIn = int'(adcCode) - 32768;   // midscale code is zero
        gainVal  = int'(gain);
        scaled   = (signedIn * gainVal) >>> `GAIN_FRAC;
        if (scaled > 32767) begin
            scaled = 32767;
        end else if (scaled < -32768) begin
            scaled = -32768;
        end
        return sample_t'(scaled + 32768);   // back to offset binary
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
    endtask

    task automatic checkIdlePins();
        assert (ADC_CONV_CS === 1'b1) else reportMismatch("ADC_CONV_CS", 1, ADC_CONV_CS);
        assert (ADC_SCK === 1'b0) else reportMismatch("ADC_SCK", 0, ADC_SCK);
        assert (ADC_SDI === 1'b0) else reportMismatch("ADC_SDI", 0, ADC_SDI);
        assert (DAC_CONV_CS === 1'b1) else reportMismatch("DAC_CONV_CS", 1, DAC_CONV_CS);
        assert (DAC_SCK === 1'b0) else reportMismatch("DAC_SCK", 0, DAC_SCK);
        assert (DAC_SDI === 1'b0) else reportMismatch("DAC_SDI", 0, DAC_SDI);
    endtask

    task automatic checkDacFrame();
        sampleBeat_t beat;
        dacWord_t    expectedWord;
        if (dacBits != `DAC_WORD_WIDTH) begin
            errorCount++;
            $display("DAC frame had %0d SCK rising edges instead of %0d", dacBits,
                     `DAC_WORD_WIDTH);
        end
        if (pending.size() == 0) begin
            errorCount++;
            $display("DAC frame arrived with no ADC sample behind it");
        end else begin
            beat         = pending.pop_front();
            expectedWord = {`DAC_TRANSMIT, 3'b000, beat.channel,
                            scaleSample(beat.sample, activeGain[beat.channel])};
            assert (dacWord[19:16] == {3'b000, nextDacCh})
                else reportMismatch("DAC channel field", nextDacCh, dacWord[19:16]);
            assert (dacWord == expectedWord)
                else reportMismatch("DAC_SDI word", expectedWord, dacWord);
            if (beat.channel && (dacWord[15:0] == 16'hFFFF || dacWord[15:0] == 16'h0000)) begin
                clampHits++;
            end
        end
        nextDacCh  = ~nextDacCh;
        activeGain = stagedGain;            // frame end commits the staged pair
        dacFrames++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // spi models, observed 1 ns after each clock edge

    always begin
        @(posedge S_AXI_ACLK);
        #1;
        if (S_AXI_ARESETN) begin
            if (prevAdcCs && !ADC_CONV_CS) begin
                adcShift = adcValue[adcPrevCh];     // answer for the previous command
                pending.push_back({adcPrevCh, adcShift});
                ADC_SDO  = adcShift[15];
                adcShift = {adcShift[14:0], 1'b0};
                adcCmd   = '0;
                adcBits  = 0;
            end else if (!ADC_CONV_CS && prevAdcSck && !ADC_SCK) begin
                ADC_SDO  = adcShift[15];
                adcShift = {adcShift[14:0], 1'b0};
            end
            if (!ADC_CONV_CS && !prevAdcSck && ADC_SCK) begin
                adcCmd = {adcCmd[14:0], ADC_SDI};
                adcBits++;
            end
            if (!prevAdcCs && ADC_CONV_CS) begin
                if (adcBits != `SAMPLE_WIDTH) begin
                    errorCount++;
                    $display("ADC frame had %0d SCK rising edges instead of %0d", adcBits,
                             `SAMPLE_WIDTH);
                end
                assert (adcCmd == expectedCmd)
                    else reportMismatch("ADC_SDI command", expectedCmd, adcCmd);
                adcPrevCh   = (adcCmd == `ADC_CMD_CH1);
                expectedCmd = (expectedCmd == `ADC_CMD_CH0) ? `ADC_CMD_CH1 : `ADC_CMD_CH0;
            end
        end
        prevAdcCs  = ADC_CONV_CS;
        prevAdcSck = ADC_SCK;
    end

    always begin
        @(posedge S_AXI_ACLK);
        #1;
        if (S_AXI_ARESETN) begin
            if (prevDacCs && !DAC_CONV_CS) begin
                dacWord = '0;
                dacBits = 0;
            end
            if (!DAC_CONV_CS && !prevDacSck && DAC_SCK) begin
                dacWord = {dacWord[22:0], DAC_SDI};
                dacBits++;
            end
            if (!prevDacCs && DAC_CONV_CS) begin
                checkDacFrame();
            end
        end
        prevDacCs  = DAC_CONV_CS;
        prevDacSck = DAC_SCK;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic applyReset();
        S_AXI_ARESETN = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge S_AXI_ACLK);
            #1;
            checkIdlePins();
        end
        S_AXI_ARESETN = 1'b1;
        checkIdlePins();                    // still reset values until the next edge
    endtask

    task automatic hostWrite(input hostAddr_t addr, input hostData_t data);
        @(posedge S_AXI_ACLK);
        #1;
        hostWr   = 1'b1;
        hostAddr = addr;
        hostData = data;
        if (addr[3:0] == `GAIN_OFFSET) begin
            stagedGain[addr[4]] = data[15:0];
        end
        @(posedge S_AXI_ACLK);
        #1;
        hostWr = 1'b0;
    endtask

    task automatic waitFrames(input int count);
        int target;
        target = dacFrames + count;
        while (dacFrames < target) begin
            @(posedge S_AXI_ACLK);
        end
    endtask

    task automatic pickRandomValues();
        adcValue[0] = sample_t'($random(seed));
        adcValue[1] = sample_t'($random(seed));
    endtask

    task automatic pickLimitValues(input logic high);
        logic [7:0] low;
        low         = 8'($random(seed));
        adcValue[0] = sample_t'($random(seed));
        adcValue[1] = high ? {8'hFF, low} : {8'h00, low};   // near full scale
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errorCount == testStartErrors) begin
            $display("test %0d %s: pass", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: fail, %0d errors", testCount, name,
                     errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        int i;
        seed            = 32'h558ea969;
        errorCount      = 0;
        failedTests     = 0;
        testCount       = 0;
        testStartErrors = 0;
        dacFrames       = 0;
        clampHits       = 0;
        adcBits         = 0;
        dacBits         = 0;
        hostWr          = 1'b0;
        hostAddr        = '0;
        hostData        = '0;
        ADC_SDO         = 1'b0;
        adcValue[0]     = 16'h1234;
        adcValue[1]     = 16'hBEEF;
        stagedGain[0]   = `GAIN_UNITY;
        stagedGain[1]   = `GAIN_UNITY;
        activeGain      = stagedGain;
        adcPrevCh       = 1'b1;             // adc answers for channel 1 first
        nextDacCh       = 1'b1;
        expectedCmd     = `ADC_CMD_CH0;
        adcShift        = '0;
        adcCmd          = '0;
        dacWord         = '0;
        prevAdcCs       = 1'b1;
        prevAdcSck      = 1'b0;
        prevDacCs       = 1'b1;
        prevDacSck      = 1'b0;

        applyReset();
        waitFrames(4);
        finishTest("reset state and unity gain");

        for (i = 0; i < 6; i++) begin
            adcValue[0] = 16'h0F00 + sample_t'(i);
            adcValue[1] = 16'hF0F0 - sample_t'(i);
            waitFrames(1);
        end
        finishTest("channel order");

        hostWrite(9'h00C, 32'h0000_2000);   // half gain on channel 0
        waitFrames(2);
        repeat (8) begin
            pickRandomValues();
            waitFrames(1);
        end
        finishTest("channel 0 gain write");

        hostWrite(9'h01C, 32'h0000_7FFF);   // almost 2x on channel 1
        pickLimitValues(1'b1);
        waitFrames(2);
        clampHits = 0;
        for (i = 0; i < 8; i++) begin
            pickLimitValues(i[1]);          // channel 1 frames see both limits
            waitFrames(1);
        end
        assert (clampHits >= 4) else begin
            errorCount++;
            $display("channel 1 output clamped in only %0d frames", clampHits);
        end
        finishTest("saturation");

        hostWrite(9'h01D, 32'h0000_0001);
        hostWrite(9'h00B, 32'h0000_1000);
        waitFrames(2);
        repeat (6) begin
            pickRandomValues();
            waitFrames(1);
        end
        finishTest("ignored write");

        assert (pending.size() <= 1) else begin
            errorCount++;
            $display("%0d ADC samples never reached the DAC", pending.size());
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d", testCount,
                 testCount - failedTests, failedTests, errorCount);
        if (errorCount == 0 && failedTests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: eqPath.f
+incdir+design
design/eqPathPkg.sv
design/gainRegs.sv
design/adcReader.sv
design/gainStage.sv
design/dacWriter.sv
design/eqPath.sv
tests/eqPathTb.sv

// File: run.sh
#!/bin/sh
# build the eqPath testbench with verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module eqPathTb -f eqPath.f -o eqPathSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/eqPathSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
